// File: verilog/fragmentPkg.sv
/*
 * Shared widths, latencies and types of the fragment colour stage
 * Pixel struct and texture environment function encoding
 */
package fragmentPkg;

    // Colour channels
    localparam int subPixelWidth = 8;
    localparam int pixelChannels = 4;
    localparam logic [subPixelWidth-1:0] channelMax = '1;

    // r in the top byte, alpha in the bottom byte
    typedef struct packed {
        logic [subPixelWidth-1:0] r;
        logic [subPixelWidth-1:0] g;
        logic [subPixelWidth-1:0] b;
        logic [subPixelWidth-1:0] a;
    } pixel_t;

    // Channel times channel, before the shift back down
    typedef logic [2*subPixelWidth-1:0] product_t;

    // Coordinates, signed, 1.0 is 0x8000
    localparam int texCoordWidth = 24;
    localparam int clampedWidth = 16;
    localparam int texAddrWidth = 8;

    // Depth and fog table
    localparam int depthWidth = 16;
    localparam int fogIndexWidth = 5;
    localparam int fogEntries = 32;
    localparam int fogEntryWidth = 8;
    localparam int lutBeatWidth = 64;
    localparam int lutEntriesPerBeat = lutBeatWidth / fogEntryWidth;
    localparam int lutPtrWidth = $clog2(fogEntries / lutEntriesPerBeat);

    // Latencies in clocks
    localparam int texReadLatency = 6;
    localparam int texEnvLatency = 2;
    localparam int fogLatency = 6;
    localparam int pipelineLatency = 1 + texReadLatency + texEnvLatency + fogLatency;

    // Texture environment functions
    typedef enum logic [1:0] {
        texReplace,
        texModulate,
        texAdd,
        texBlend
    } texEnvFunc_t;

endpackage

// File: verilog/lutStreamIf.sv
/*
 * Fog table stream, valid/ready/last handshake with one data beat
 */
interface lutStreamIf;

    // Beat moves when valid and ready are both high
    logic valid;
    logic ready;
    // Closes a table, next beat starts at entry 0
    logic last;
    // Eight intensities, entry 0 in the low byte
    logic [fragmentPkg::lutBeatWidth-1:0] data;

    modport source
    (
        output valid,
        output last,
        output data,
        input  ready
    );

    modport sink
    (
        input  valid,
        input  last,
        input  data,
        output ready
    );

endinterface

// File: verilog/valueDelay.sv
/*
 * Fixed-length shift register for any payload type
 */
module valueDelay
#(
    parameter type payload_t = logic,
    parameter int depth = 1
)
(
    input  logic     aclk,
    input  payload_t din,
    output payload_t dout
);

    // One register per clock of delay
    payload_t stages [depth];

    always_ff @(posedge aclk)
    begin
        stages[0] <= din;
        for (int i = 1; i < depth; i++)
        begin
            stages[i] <= stages[i-1];
        end
    end

    // Oldest stage
    assign dout = stages[depth-1];

endmodule

// File: verilog/textureMemory.sv
/*
 * 256-texel texture memory
 * Synchronous write port, six-clock read pipeline
 */
module textureMemory
(
    input  logic                                aclk,
    input  logic                                texWriteEn,
    input  logic [fragmentPkg::texAddrWidth-1:0] texWriteAddr,
    input  fragmentPkg::pixel_t                 texWriteData,
    input  logic [fragmentPkg::texAddrWidth-1:0] texAddr,
    output fragmentPkg::pixel_t                 texel
);

    fragmentPkg::pixel_t memory [2**fragmentPkg::texAddrWidth];

    // Read clock 1, address register
    logic [fragmentPkg::texAddrWidth-1:0] addrReg;

    // Read clock 2 is the array read, clocks 3 to 6 only retime the texel
    fragmentPkg::pixel_t readStage [fragmentPkg::texReadLatency-1];

    // Same-address write and read in one clock returns the old texel
    always_ff @(posedge aclk)
    begin
        if (texWriteEn)
        begin
            memory[texWriteAddr] <= texWriteData;
        end
    end

    always_ff @(posedge aclk)
    begin
        addrReg <= texAddr;
        readStage[0] <= memory[addrReg];
        for (int i = 1; i < fragmentPkg::texReadLatency - 1; i++)
        begin
            readStage[i] <= readStage[i-1];
        end
    end

    assign texel = readStage[fragmentPkg::texReadLatency-2];

endmodule

// File: verilog/texEnv.sv
/*
 * Texture environment combiner, two clocks
 * Replace, modulate, add and blend on all four channels
 */
module texEnv
(
    input  logic                     aclk,
    input  fragmentPkg::texEnvFunc_t func,
    input  fragmentPkg::pixel_t      texColor,
    input  fragmentPkg::pixel_t      primaryColor,
    input  fragmentPkg::pixel_t      envColor,
    output fragmentPkg::pixel_t      color
);

    // Channel views, index 0 is alpha
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] texCh;
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] primCh;
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] envCh;
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] resultCh;

    // Stage 1 results
    fragmentPkg::texEnvFunc_t funcReg;
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] texReg;
    fragmentPkg::product_t [fragmentPkg::pixelChannels-1:0] modProd;
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth:0] addSum;
    fragmentPkg::product_t [fragmentPkg::pixelChannels-1:0] blendSum;

    assign texCh = texColor;
    assign primCh = primaryColor;
    assign envCh = envColor;

    // Stage 1, every candidate at once
    // Blend sum peaks at 255 * 255, fits the product width
    always_ff @(posedge aclk)
    begin
        funcReg <= func;
        for (int i = 0; i < fragmentPkg::pixelChannels; i++)
        begin
            texReg[i] <= texCh[i];
            modProd[i] <= fragmentPkg::product_t'(texCh[i]) * fragmentPkg::product_t'(primCh[i]);
            addSum[i] <= {1'b0, texCh[i]} + {1'b0, primCh[i]};
            blendSum[i] <= fragmentPkg::product_t'(primCh[i])
                * fragmentPkg::product_t'(fragmentPkg::channelMax - texCh[i])
                + fragmentPkg::product_t'(envCh[i]) * fragmentPkg::product_t'(texCh[i]);
        end
    end

    // Stage 2, pick by function
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < fragmentPkg::pixelChannels; i++)
        begin
            case (funcReg)
                fragmentPkg::texReplace:
                    resultCh[i] <= texReg[i];
                fragmentPkg::texModulate:
                    resultCh[i] <= modProd[i][2*fragmentPkg::subPixelWidth-1 -: fragmentPkg::subPixelWidth];
                fragmentPkg::texAdd:
                    // Carry out means saturate
                    resultCh[i] <= addSum[i][fragmentPkg::subPixelWidth] ? fragmentPkg::channelMax
                        : addSum[i][fragmentPkg::subPixelWidth-1:0];
                default:
                    resultCh[i] <= blendSum[i][2*fragmentPkg::subPixelWidth-1 -: fragmentPkg::subPixelWidth];
            endcase
        end
    end

    assign color = resultCh;

endmodule

// File: verilog/fogUnit.sv
/*
 * Fog unit, 32-entry intensity table with its stream loader
 * Six-clock fog blend indexed by depth
 */
module fogUnit
(
    input  logic                              aclk,
    input  logic                              rst,
    lutStreamIf.sink                          lut,
    input  logic                              fogEnable,
    input  fragmentPkg::pixel_t               fogColor,
    input  logic [fragmentPkg::depthWidth-1:0] depth,
    input  fragmentPkg::pixel_t               texelColor,
    output fragmentPkg::pixel_t               color
);

    logic [fragmentPkg::fogEntryWidth-1:0] fogTable [fragmentPkg::fogEntries];

    //////////////////////////////////////////////////////////////////////
    // Table loader
    //////////////////////////////////////////////////////////////////////

    // Beat pointer, one beat fills eight entries
    logic [fragmentPkg::lutPtrWidth-1:0] beatPtr;
    logic readyReg;
    logic beatAccepted;

    assign beatAccepted = lut.valid && lut.ready;
    assign lut.ready = readyReg;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            beatPtr <= '0;
            readyReg <= 1'b0;
        end
        else
        begin
            // Never back-pressures once out of reset
            readyReg <= 1'b1;
            if (beatAccepted)
            begin
                beatPtr <= lut.last ? '0 : beatPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (beatAccepted)
        begin
            for (int i = 0; i < fragmentPkg::lutEntriesPerBeat; i++)
            begin
                fogTable[int'(beatPtr) * fragmentPkg::lutEntriesPerBeat + i]
                    <= lut.data[i*fragmentPkg::fogEntryWidth +: fragmentPkg::fogEntryWidth];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fog blend
    //////////////////////////////////////////////////////////////////////

    // Texel and enable ride along stages 1 to 5
    fragmentPkg::pixel_t texelPipe [fragmentPkg::fogLatency-1];
    logic enablePipe [fragmentPkg::fogLatency-1];

    logic [fragmentPkg::fogIndexWidth-1:0] fogIndex;
    logic [fragmentPkg::fogEntryWidth-1:0] intensity;
    fragmentPkg::pixel_t fogColorS1;
    fragmentPkg::pixel_t fogColorS2;

    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] texelCh;
    logic [fragmentPkg::pixelChannels-1:0][fragmentPkg::subPixelWidth-1:0] fogCh;

    // Alpha bypasses the blend, so only r, g, b
    fragmentPkg::product_t [fragmentPkg::pixelChannels-1:1] texProd;
    fragmentPkg::product_t [fragmentPkg::pixelChannels-1:1] fogProd;
    fragmentPkg::product_t [fragmentPkg::pixelChannels-1:1] blendSum;
    logic [fragmentPkg::pixelChannels-1:1][fragmentPkg::subPixelWidth-1:0] blended;

    assign texelCh = texelPipe[1];
    assign fogCh = fogColorS2;

    always_ff @(posedge aclk)
    begin
        // Stage 1, table index from the top depth bits
        fogIndex <= depth[fragmentPkg::depthWidth-1 -: fragmentPkg::fogIndexWidth];
        fogColorS1 <= fogColor;
        texelPipe[0] <= texelColor;
        enablePipe[0] <= fogEnable;
        for (int k = 1; k < fragmentPkg::fogLatency - 1; k++)
        begin
            texelPipe[k] <= texelPipe[k-1];
            enablePipe[k] <= enablePipe[k-1];
        end

        // Stage 2, table read
        intensity <= fogTable[fogIndex];
        fogColorS2 <= fogColorS1;

        for (int i = 1; i < fragmentPkg::pixelChannels; i++)
        begin
            // Stage 3, texel weighted by f, fog colour by 255 - f
            texProd[i] <= fragmentPkg::product_t'(texelCh[i]) * fragmentPkg::product_t'(intensity);
            fogProd[i] <= fragmentPkg::product_t'(fogCh[i])
                * fragmentPkg::product_t'(fragmentPkg::channelMax - intensity);
            // Stage 4, sum
            blendSum[i] <= texProd[i] + fogProd[i];
            // Stage 5, back to channel width
            blended[i] <= blendSum[i][2*fragmentPkg::subPixelWidth-1 -: fragmentPkg::subPixelWidth];
        end

        // Stage 6, fogged or untouched
        color <= enablePipe[fragmentPkg::fogLatency-2]
            ? {blended, texelPipe[fragmentPkg::fogLatency-2].a}
            : texelPipe[fragmentPkg::fogLatency-2];
    end

endmodule

// File: verilog/fragmentPipeline.sv
/*
 * Fragment colour pipeline, 15 clocks
 * Coordinate clamp, texel request, delay alignment, combiner and fog
 */
module fragmentPipeline
(
    input  logic                                 aclk,
    input  logic                                 rst,
    lutStreamIf.sink                             lut,
    input  fragmentPkg::texEnvFunc_t             texEnvFunc,
    input  logic                                 fogEnable,
    input  logic                                 clampS,
    input  logic                                 clampT,
    input  fragmentPkg::pixel_t                  texEnvColor,
    input  fragmentPkg::pixel_t                  fogColor,
    output logic [fragmentPkg::texAddrWidth-1:0] texAddr,
    input  fragmentPkg::pixel_t                  texel,
    input  fragmentPkg::pixel_t                  triangleColor,
    input  logic [fragmentPkg::depthWidth-1:0]   depth,
    input  logic [fragmentPkg::texCoordWidth-1:0] textureS,
    input  logic [fragmentPkg::texCoordWidth-1:0] textureT,
    output fragmentPkg::pixel_t                  fragmentColor
);

    // Configuration travels with its fragment
    typedef struct packed {
        fragmentPkg::pixel_t      color;
        fragmentPkg::texEnvFunc_t func;
        fragmentPkg::pixel_t      envColor;
    } colorStage_t;

    typedef struct packed {
        logic [fragmentPkg::depthWidth-1:0] depth;
        logic                               fogEnable;
        fragmentPkg::pixel_t                fogColor;
    } depthStage_t;

    // Clamp to [0, 0x7fff] in clamp mode, else keep the fraction bits for repeat
    function automatic logic [fragmentPkg::clampedWidth-1:0] clampCoord
    (
        input logic [fragmentPkg::texCoordWidth-1:0] coord,
        input logic                                  clampMode
    );
        logic [fragmentPkg::clampedWidth-1:0] result;
        result = coord[fragmentPkg::clampedWidth-1:0];
        if (clampMode)
        begin
            if (coord[fragmentPkg::texCoordWidth-1])
                result = '0;
            else if (coord[fragmentPkg::texCoordWidth-2:fragmentPkg::clampedWidth-1] != '0)
                result = 16'h7fff;
        end
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Step 0, clamp and texel request
    //////////////////////////////////////////////////////////////////////
    logic [fragmentPkg::clampedWidth-1:0] clampedS;
    logic [fragmentPkg::clampedWidth-1:0] clampedT;
    colorStage_t colorStage0;
    depthStage_t depthStage0;

    always_ff @(posedge aclk)
    begin
        clampedS <= clampCoord(textureS, clampS);
        clampedT <= clampCoord(textureT, clampT);
        colorStage0 <= '{color: triangleColor, func: texEnvFunc, envColor: texEnvColor};
        depthStage0 <= '{depth: depth, fogEnable: fogEnable, fogColor: fogColor};
    end

    // t nibble high, s nibble low
    assign texAddr = {clampedT[14:11], clampedS[14:11]};

    //////////////////////////////////////////////////////////////////////
    // Steps 1 and 2, wait for texel, combine, then fog
    //////////////////////////////////////////////////////////////////////
    colorStage_t colorAligned;
    depthStage_t depthAligned;
    fragmentPkg::pixel_t texEnvOut;

    // Lines up with the returning texel
    valueDelay #(.payload_t(colorStage_t), .depth(fragmentPkg::texReadLatency)) colorDelay
    (
        .aclk(aclk),
        .din (colorStage0),
        .dout(colorAligned)
    );

    // Lines up with the combiner output
    valueDelay #(
        .payload_t(depthStage_t),
        .depth    (fragmentPkg::texReadLatency + fragmentPkg::texEnvLatency)
    ) depthDelay
    (
        .aclk(aclk),
        .din (depthStage0),
        .dout(depthAligned)
    );

    texEnv combiner
    (
        .aclk        (aclk),
        .func        (colorAligned.func),
        .texColor    (texel),
        .primaryColor(colorAligned.color),
        .envColor    (colorAligned.envColor),
        .color       (texEnvOut)
    );

    fogUnit fog
    (
        .aclk      (aclk),
        .rst       (rst),
        .lut       (lut),
        .fogEnable (depthAligned.fogEnable),
        .fogColor  (depthAligned.fogColor),
        .depth     (depthAligned.depth),
        .texelColor(texEnvOut),
        .color     (fragmentColor)
    );

endmodule

// File: verilog/fragmentTop.sv
/*
 * Top level, fragment pipeline with its texture memory and table stream
 */
module fragmentTop
(
    input  logic                                  aclk,
    input  logic                                  rst,
    input  logic                                  lutValid,
    output logic                                  lutReady,
    input  logic                                  lutLast,
    input  logic [fragmentPkg::lutBeatWidth-1:0]  lutData,
    input  fragmentPkg::texEnvFunc_t              texEnvFunc,
    input  logic                                  fogEnable,
    input  logic                                  clampS,
    input  logic                                  clampT,
    input  fragmentPkg::pixel_t                   texEnvColor,
    input  fragmentPkg::pixel_t                   fogColor,
    input  logic                                  texWriteEn,
    input  logic [fragmentPkg::texAddrWidth-1:0]  texWriteAddr,
    input  fragmentPkg::pixel_t                   texWriteData,
    input  fragmentPkg::pixel_t                   triangleColor,
    input  logic [fragmentPkg::depthWidth-1:0]    depth,
    input  logic [fragmentPkg::texCoordWidth-1:0] textureS,
    input  logic [fragmentPkg::texCoordWidth-1:0] textureT,
    output fragmentPkg::pixel_t                   fragmentColor
);

    // Plain ports onto the source side of the stream
    lutStreamIf lutStream ();

    assign lutStream.valid = lutValid;
    assign lutStream.last = lutLast;
    assign lutStream.data = lutData;
    assign lutReady = lutStream.ready;

    // Texel fetch
    logic [fragmentPkg::texAddrWidth-1:0] texAddr;
    fragmentPkg::pixel_t texel;

    fragmentPipeline pipeline
    (
        .aclk         (aclk),
        .rst          (rst),
        .lut          (lutStream.sink),
        .texEnvFunc   (texEnvFunc),
        .fogEnable    (fogEnable),
        .clampS       (clampS),
        .clampT       (clampT),
        .texEnvColor  (texEnvColor),
        .fogColor     (fogColor),
        .texAddr      (texAddr),
        .texel        (texel),
        .triangleColor(triangleColor),
        .depth        (depth),
        .textureS     (textureS),
        .textureT     (textureT),
        .fragmentColor(fragmentColor)
    );

    textureMemory texMemory
    (
        .aclk        (aclk),
        .texWriteEn  (texWriteEn),
        .texWriteAddr(texWriteAddr),
        .texWriteData(texWriteData),
        .texAddr     (texAddr),
        .texel       (texel)
    );

endmodule

// File: tb/fragmentPipeline_asserts.sv
/*
 * Concurrent checks on the fragment pipeline
 * Stream ready, clamp range and a defined output colour
 */
module fragmentPipeline_asserts
(
    input logic                                 aclk,
    input logic                                 rst,
    input logic                                 lutReady,
    input logic                                 clampS,
    input logic                                 clampT,
    input logic [fragmentPkg::clampedWidth-1:0] clampedS,
    input logic [fragmentPkg::clampedWidth-1:0] clampedT,
    input fragmentPkg::pixel_t                  fragmentColor
);

    // Clocks since reset ended
    // First fragment enters on the first of them
    int cyclesOutOfReset;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            cyclesOutOfReset <= 0;
        end
        else if (cyclesOutOfReset <= fragmentPkg::pipelineLatency)
        begin
            cyclesOutOfReset <= cyclesOutOfReset + 1;
        end
    end

    // Ready register rises one clock after reset and stays up
    readyAfterReset: assert property (@(posedge aclk) disable iff (rst)
        !$past(rst) |-> lutReady)
        else $error("lut ready dropped outside reset");

    // Clamp mode holds the coordinate inside [0, 1.0)
    clampRangeS: assert property (@(posedge aclk) disable iff (rst)
        $past(clampS) |-> clampedS <= 16'h7fff)
        else $error("clamped s above 0x7fff");

    clampRangeT: assert property (@(posedge aclk) disable iff (rst)
        $past(clampT) |-> clampedT <= 16'h7fff)
        else $error("clamped t above 0x7fff");

    // Once the first fragment has crossed all 15 stages
    colorDefined: assert property (@(posedge aclk) disable iff (rst)
        (cyclesOutOfReset > fragmentPkg::pipelineLatency) |-> !$isunknown(fragmentColor))
        else $error("fragmentColor carries X");

endmodule

// File: tb/fragmentTb.sv
/*
 * Testbench for the fragment colour stage
 * Reference models, directed tests, compare tasks and cycle timeout
 */
module fragmentTb;

    // Tests take roughly 700 clocks, texture load included
    localparam int timeoutCycles = 2000;
    localparam int randomSeed = 32'h1bab_7bdf;

    logic aclk;
    logic rst;
    logic lutValid;
    logic lutReady;
    logic lutLast;
    logic [fragmentPkg::lutBeatWidth-1:0] lutData;
    fragmentPkg::texEnvFunc_t texEnvFunc;
    logic fogEnable;
    logic clampS;
    logic clampT;
    fragmentPkg::pixel_t texEnvColor;
    fragmentPkg::pixel_t fogColor;
    logic texWriteEn;
    logic [fragmentPkg::texAddrWidth-1:0] texWriteAddr;
    fragmentPkg::pixel_t texWriteData;
    fragmentPkg::pixel_t triangleColor;
    logic [fragmentPkg::depthWidth-1:0] depth;
    logic [fragmentPkg::texCoordWidth-1:0] textureS;
    logic [fragmentPkg::texCoordWidth-1:0] textureT;
    fragmentPkg::pixel_t fragmentColor;

    // Model copies of texture and fog table
    fragmentPkg::pixel_t texModel [2**fragmentPkg::texAddrWidth];
    logic [fragmentPkg::fogEntryWidth-1:0] fogModel [fragmentPkg::fogEntries];

    // Expected colours with the cycle they are due in
    fragmentPkg::pixel_t expectQ [$];
    int dueQ [$];
    int cycle = 0;
    int errors = 0;

    fragmentTop DUT
    (
        .aclk(aclk), .rst(rst),
        .lutValid(lutValid), .lutReady(lutReady), .lutLast(lutLast), .lutData(lutData),
        .texEnvFunc(texEnvFunc), .fogEnable(fogEnable), .clampS(clampS), .clampT(clampT),
        .texEnvColor(texEnvColor), .fogColor(fogColor),
        .texWriteEn(texWriteEn), .texWriteAddr(texWriteAddr), .texWriteData(texWriteData),
        .triangleColor(triangleColor), .depth(depth),
        .textureS(textureS), .textureT(textureT),
        .fragmentColor(fragmentColor)
    );

    bind fragmentPipeline fragmentPipeline_asserts pipelineAsserts
    (
        .aclk(aclk), .rst(rst), .lutReady(lut.ready),
        .clampS(clampS), .clampT(clampT), .clampedS(clampedS), .clampedT(clampedT),
        .fragmentColor(fragmentColor)
    );

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    // Cycle count and run limit
    always @(posedge aclk)
    begin
        cycle = cycle + 1;
        if (cycle >= timeoutCycles)
        begin
            $display("Timeout, the tests did not finish within %0d cycles", timeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Output compare, on the falling edge where fragmentColor is stable
    always @(negedge aclk)
    begin
        if (dueQ.size() > 0 && dueQ[0] == cycle)
        begin
            checkPixel("fragmentColor", fragmentColor, expectQ[0]);
            void'(expectQ.pop_front());
            void'(dueQ.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkPixel(input string name, input fragmentPkg::pixel_t actual,
        input fragmentPkg::pixel_t expected);
        if (actual !== expected)
        begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkReady();
        if (lutReady !== 1'b1)
        begin
            errors++;
            $display("Fog table stream is not ready at %0t although reset has ended", $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference models
    //////////////////////////////////////////////////////////////////////

    // Negative clamps to 0, 1.0 and above to just below 1.0
    function automatic logic [15:0] wrapOrClamp(input logic [23:0] coord, input logic clampOn);
        int value;
        value = $signed(coord);
        if (clampOn && value < 0)
            return 16'h0000;
        if (clampOn && value >= 32'h8000)
            return 16'h7fff;
        return coord[15:0];
    endfunction

    function automatic fragmentPkg::pixel_t combineExpected(input fragmentPkg::texEnvFunc_t func,
        input fragmentPkg::pixel_t tex, input fragmentPkg::pixel_t prim,
        input fragmentPkg::pixel_t env);
        logic [31:0] t;
        logic [31:0] p;
        logic [31:0] e;
        logic [31:0] result;
        int tc;
        int pc;
        int ec;
        int rc;
        t = tex;
        p = prim;
        e = env;
        for (int i = 0; i < 4; i++)
        begin
            tc = int'(t[8*i +: 8]);
            pc = int'(p[8*i +: 8]);
            ec = int'(e[8*i +: 8]);
            case (func)
                fragmentPkg::texReplace: rc = tc;
                fragmentPkg::texModulate: rc = (tc * pc) / 256;
                fragmentPkg::texAdd: rc = (tc + pc > 255) ? 255 : tc + pc;
                default: rc = (pc * (255 - tc) + ec * tc) / 256;
            endcase
            result[8*i +: 8] = 8'(rc);
        end
        return result;
    endfunction

    // Alpha in the low byte is left alone
    function automatic fragmentPkg::pixel_t fogExpected(input fragmentPkg::pixel_t col,
        input fragmentPkg::pixel_t fogCol, input logic [15:0] dep);
        logic [31:0] c;
        logic [31:0] fc;
        logic [31:0] result;
        int f;
        c = col;
        fc = fogCol;
        f = int'(fogModel[dep[15:11]]);
        result = c;
        for (int i = 1; i < 4; i++)
        begin
            result[8*i +: 8] = 8'((int'(c[8*i +: 8]) * f + int'(fc[8*i +: 8]) * (255 - f)) / 256);
        end
        return result;
    endfunction

    // Expected colour of the fragment now on the inputs
    function automatic fragmentPkg::pixel_t predictColor();
        logic [15:0] s;
        logic [15:0] t;
        fragmentPkg::pixel_t combined;
        s = wrapOrClamp(textureS, clampS);
        t = wrapOrClamp(textureT, clampT);
        combined = combineExpected(texEnvFunc, texModel[{t[14:11], s[14:11]}],
            triangleColor, texEnvColor);
        return fogEnable ? fogExpected(combined, fogColor, depth) : combined;
    endfunction

    function automatic fragmentPkg::pixel_t randomPixel();
        return fragmentPkg::pixel_t'($urandom);
    endfunction

    // Mostly around [0, 1.0), some anywhere in the 24-bit range
    function automatic logic [23:0] randomCoord();
        if ($urandom_range(3, 0) == 0)
            return 24'($urandom);
        return 24'($urandom_range(32'h17fff, 0)) - 24'h004000;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    // Texel 0 goes first, fragments during the load all read it
    task automatic loadTexture();
        fragmentPkg::pixel_t value;
        for (int addr = 0; addr < 256; addr++)
        begin
            value = '{r: 8'(addr), g: 8'(addr * 37 + 11), b: 8'(~addr), a: 8'(addr ^ 8'h96)};
            texModel[addr] = value;
            texWriteEn = 1'b1;
            texWriteAddr = 8'(addr);
            texWriteData = value;
            @(negedge aclk);
        end
        texWriteEn = 1'b0;
    endtask

    // Four beats of a linear intensity ramp, last on the fourth
    task automatic streamFogTable(input int first, input int step);
        logic [63:0] beat;
        for (int b = 0; b < 4; b++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                fogModel[b*8 + k] = 8'(first + step * (b*8 + k));
                beat[8*k +: 8] = 8'(first + step * (b*8 + k));
            end
            lutValid = 1'b1;
            lutLast = (b == 3);
            lutData = beat;
            checkReady();
            // Ready seen here is what the next rising edge samples
            while (!lutReady)
                @(negedge aclk);
            @(negedge aclk);
        end
        lutValid = 1'b0;
        lutLast = 1'b0;
    endtask

    // Fragment enters on the next rising edge
    task automatic sendFragment();
        expectQ.push_back(predictColor());
        dueQ.push_back(cycle + fragmentPkg::pipelineLatency);
        @(negedge aclk);
    endtask

    task automatic drainPipeline();
        while (dueQ.size() > 0)
            @(negedge aclk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic envFunctions();
        fogEnable = 1'b0;
        clampS = 1'b0;
        clampT = 1'b0;
        for (int f = 0; f < 4; f++)
        begin
            for (int n = 0; n < 3; n++)
            begin
                texEnvFunc = fragmentPkg::texEnvFunc_t'(f);
                triangleColor = (n == 0) ? 32'hff80_40_01 : randomPixel();
                texEnvColor = randomPixel();
                textureS = {9'd0, 4'(f * 3 + n), 11'h155};
                textureT = {9'd0, 4'(n * 5 + 1), 11'h0aa};
                sendFragment();
            end
        end
        drainPipeline();
    endtask

    task automatic clampAndRepeat();
        logic [23:0] coords [8] = '{24'hfff000, 24'h800000, 24'h008000, 24'h01a800,
            24'h7fffff, 24'h003800, 24'h007fff, 24'h000000};
        fogEnable = 1'b0;
        texEnvFunc = fragmentPkg::texReplace;
        for (int mode = 0; mode < 4; mode++)
        begin
            for (int i = 0; i < 8; i++)
            begin
                clampS = mode[0];
                clampT = mode[1];
                textureS = coords[i];
                textureT = coords[(i + 3) % 8];
                sendFragment();
            end
        end
        drainPipeline();
    endtask

    // One fragment per table index
    task automatic fogSweep(input fragmentPkg::pixel_t fogCol);
        fogEnable = 1'b1;
        fogColor = fogCol;
        texEnvFunc = fragmentPkg::texReplace;
        for (int idx = 0; idx < fragmentPkg::fogEntries; idx++)
        begin
            depth = {5'(idx), 11'($urandom)};
            clampS = 1'($urandom);
            clampT = 1'($urandom);
            textureS = randomCoord();
            textureT = randomCoord();
            sendFragment();
        end
        drainPipeline();
    endtask

    task automatic randomBurst();
        fogEnable = 1'b1;
        for (int n = 0; n < 200; n++)
        begin
            texEnvFunc = fragmentPkg::texEnvFunc_t'($urandom_range(3, 0));
            triangleColor = randomPixel();
            texEnvColor = randomPixel();
            fogColor = randomPixel();
            depth = 16'($urandom);
            clampS = 1'($urandom);
            clampT = 1'($urandom);
            textureS = randomCoord();
            textureT = randomCoord();
            sendFragment();
        end
        drainPipeline();
    endtask

    initial
    begin
        void'($urandom(randomSeed));
        rst = 1'b1;
        lutValid = 1'b0;
        lutLast = 1'b0;
        lutData = '0;
        texEnvFunc = fragmentPkg::texReplace;
        fogEnable = 1'b0;
        clampS = 1'b0;
        clampT = 1'b0;
        texEnvColor = '0;
        fogColor = '0;
        texWriteEn = 1'b0;
        texWriteAddr = '0;
        texWriteData = '0;
        triangleColor = '0;
        depth = '0;
        textureS = '0;
        textureT = '0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        loadTexture();
        streamFogTable(3, 8);
        envFunctions();
        clampAndRepeat();
        fogSweep(32'h20_60_c0_ff);
        randomBurst();
        // Ascending ramp replaced by a descending one
        streamFogTable(250, -7);
        fogSweep(32'hd0_30_90_00);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: fragmentPipeline.f
verilog/fragmentPkg.sv
verilog/lutStreamIf.sv
verilog/valueDelay.sv
verilog/textureMemory.sv
verilog/texEnv.sv
verilog/fogUnit.sv
verilog/fragmentPipeline.sv
verilog/fragmentTop.sv
tb/fragmentPipeline_asserts.sv
tb/fragmentTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the fragment pipeline testbench with Verilator, run it, then grep the log

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module fragmentTb \
    -f fragmentPipeline.f -o simFragment > "$LOG" 2>&1 \
    && ./obj_dir/simFragment >> "$LOG" 2>&1 \
    || echo "Build or simulation ended with an error, see $LOG"

grep -qF '*** TEST PASSED ***' "$LOG" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see $LOG"; exit 1; }
